//--- median_filter.f
+incdir+include
hdl/median_filter_pkg.sv
hdl/channel_median.sv
hdl/window_capture.sv
hdl/window_sequencer.sv
hdl/median_filter.sv
sim/tb_median_filter.sv

//--- run_sim.sh
#!/bin/sh
# Build the median filter testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/10ps \
  -f median_filter.f \
  --top-module tb_median_filter \
  -o tb_median_filter

./obj_dir/tb_median_filter > sim.log 2>&1
cat sim.log

if grep -q "TEST PASS" sim.log; then
  exit 0
else
  exit 1
fi

//--- include/tb_case_table.svh
// Test cases, one row each, applied in order
// Columns: index, name, image mode, LFSR seed, abort cycles (0 runs the full pass)

localparam int mode_random    = 0;  // LFSR pixels
localparam int mode_saturated = 1;  // Every channel 255
localparam int mode_ramp      = 2;  // Address-derived pixels
localparam int case_count     = 6;

string       case_name  [case_count];
int          case_mode  [case_count];
logic [15:0] case_seed  [case_count];
int          case_abort [case_count];

task automatic add_case(input int          index,
                        input string       name,
                        input int          mode,
                        input logic [15:0] seed,
                        input int          abort_cycles);
  case_name[index]  = name;
  case_mode[index]  = mode;
  case_seed[index]  = seed;
  case_abort[index] = abort_cycles;   // Cycles after enable rises
endtask

task automatic load_cases();
  add_case(0, "random_seed_a",  mode_random,    16'd26598, 0);
  add_case(1, "random_seed_b",  mode_random,    16'hace1,  0);
  add_case(2, "saturated",      mode_saturated, 16'd1,     0);    // Every median clamps
  add_case(3, "abort_early",    mode_random,    16'h5eed,  5);    // Inside the first pixel
  add_case(4, "abort_mid_pass", mode_random,    16'h0b3d,  120);  // Around centre 10
  add_case(5, "ramp_restart",   mode_ramp,      16'd1,     0);    // Full pass after aborts
endtask

//--- sim/tb_median_filter.sv
`timescale 1ns/10ps

module tb_median_filter;

  localparam int image_width      = 8;
  localparam int image_height     = 5;
  localparam int pixel_count      = image_width * image_height;        // Guard word sits here
  localparam int centre_count     = image_width * (image_height - 2);  // N
  localparam int cycles_per_pixel = 11;
  localparam int pass_cycles      = 1 + cycles_per_pixel * centre_count;  // Start to done
  localparam int memory_depth     = 2 ** median_filter_pkg::address_width;
  localparam int abort_watch      = 3 * cycles_per_pixel;
  localparam int hold_cycles      = 4;

  `include "tb_case_table.svh"

  localparam int case_margin = 60;  // Start, hold, release and idle gap per case
  localparam int cycle_limit = case_count * (pass_cycles + case_margin) + 64;

  logic                                        clk;
  logic                                        reset;
  logic                                        enable;
  logic [median_filter_pkg::word_width-1:0]    data_read = '0;
  logic [median_filter_pkg::address_width-1:0] address;
  logic [median_filter_pkg::word_width-1:0]    data_write;
  logic                                        wren;
  logic                                        done;

  logic [31:0] mem [memory_depth];      // Full 18-bit space, neighbours wrap below zero
  logic [31:0] expected [centre_count];
  int          error_count;
  int          write_count;             // Writes in the current pass
  int          checked_count;
  int          cycle_count = 0;
  logic        wren_prev;
  logic [15:0] lfsr;
  string       case_label;

  median_filter #(
    .image_width  (image_width),
    .image_height (image_height)
  ) i_median_filter (
    .clk        (clk),
    .reset      (reset),
    .enable     (enable),
    .data_read  (data_read),
    .address    (address),
    .data_write (data_write),
    .wren       (wren),
    .done       (done)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;   // 100 ns period
  end

  // One cycle read latency
  always @(posedge clk) begin
    data_read <= mem[address];
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("TEST FAIL");
      $finish;
    end
  end

  // Galois form, taps 16,14,13,11
  function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 16'hb400;
    end
    return state >> 1;
  endfunction

  task automatic random_word(output logic [31:0] word);
    for (int b = 0; b < 32; b++) begin
      lfsr    = lfsr_step(lfsr);    // One step per bit
      word[b] = lfsr[0];
    end
  endtask

  function automatic logic [31:0] ramp_word(input int a);
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
    red   = 8'(a * 7);
    green = 8'(255 - a);            // 255 at address 0
    blue  = 8'(a * 13 + 5);
    return {blue, 8'(a), green, red};  // Byte 2 nonzero, must not leak out
  endfunction

  task automatic fill_memory(input int mode);
    logic [31:0] word;
    for (int a = 0; a < memory_depth; a++) begin
      mem[18'(a)] = {14'h2a5, 18'(a)};   // Background tied to the full address
    end
    // Image plus the guard word at pixel_count
    for (int a = 0; a <= pixel_count; a++) begin
      case (mode)
        mode_random:    random_word(word);
        mode_saturated: word = 32'hffff_ffff;
        default:        word = ramp_word(a);
      endcase
      mem[18'(a)] = word;
    end
  endtask

  // Plain sort of the nine bytes, then the marker clamp
  function automatic logic [7:0] median_of_nine(input logic [71:0] values);
    logic [7:0] s [9];
    logic [7:0] t;
    for (int i = 0; i < 9; i++) begin
      s[i] = values[i*8 +: 8];
    end
    for (int i = 0; i < 8; i++) begin
      for (int j = 0; j < 8 - i; j++) begin
        if (s[j] > s[j+1]) begin
          t      = s[j];
          s[j]   = s[j+1];
          s[j+1] = t;
        end
      end
    end
    if (s[4] == 8'd255) begin
      return 8'd254;
    end
    return s[4];
  endfunction

  task automatic compute_expected();
    int          offsets [9];
    logic [17:0] centre;
    logic [17:0] a;
    logic [71:0] red_values;
    logic [71:0] green_values;
    logic [71:0] blue_values;
    // Linear neighbours, row ends wrap
    offsets = '{0, -1, 1, 1 - image_width, -image_width, -1 - image_width,
                image_width - 1, image_width, image_width + 1};
    for (int k = 0; k < centre_count; k++) begin
      centre = 18'(image_width + k);
      for (int n = 0; n < 9; n++) begin
        a = centre + 18'(offsets[n]);   // Modulo 2^18
        red_values[n*8 +: 8]   = mem[a][7:0];
        green_values[n*8 +: 8] = mem[a][15:8];
        blue_values[n*8 +: 8]  = mem[a][31:24];
      end
      expected[k] = {median_of_nine(blue_values), 8'h00,
                     median_of_nine(green_values), median_of_nine(red_values)};
    end
  endtask

  task automatic check_value(input string       name,
                             input logic [31:0] expected_value,
                             input logic [31:0] actual_value);
    if (expected_value !== actual_value) begin
      $display("error %s expected %h actual %h", name, expected_value, actual_value);
      error_count++;
    end
  endtask

  // Outputs read here are the values from before the edge
  task automatic sample_cycle();
    @(posedge clk);
    if (wren) begin
      check_value({case_label, " wren width"}, 32'd0, 32'(wren_prev));
      check_value({case_label, " write address"},
                  32'(pixel_count + 1 + write_count), 32'(address));
      mem[address] = data_write;        // RAM write at this edge
      write_count++;
    end
    wren_prev = wren;
  endtask

  task automatic run_case(input int index);
    int edges;
    int writes_at_abort;
    case_label = case_name[index];
    lfsr       = case_seed[index];
    fill_memory(case_mode[index]);
    compute_expected();
    write_count = 0;
    wren_prev   = 1'b0;
    edges       = 0;
    enable <= 1'b1;                   // DUT samples it at the next edge
    if (case_abort[index] > 0) begin
      repeat (case_abort[index]) sample_cycle();
      enable <= 1'b0;
      sample_cycle();                 // A write from before the abort may still land
      writes_at_abort = write_count;
      repeat (abort_watch) begin
        sample_cycle();
        check_value({case_label, " done after abort"}, 32'd0, 32'(done));
      end
      check_value({case_label, " writes after abort"},
                  32'(writes_at_abort), 32'(write_count));
    end else begin
      while (done !== 1'b1) begin
        sample_cycle();
        edges++;
      end
      // Start edge is one after the drive, rise is seen one edge late
      check_value({case_label, " done delay"}, 32'(pass_cycles), 32'(edges - 2));
      check_value({case_label, " write count"}, 32'(centre_count), 32'(write_count));
      repeat (hold_cycles) begin
        sample_cycle();
        check_value({case_label, " done hold"}, 32'd1, 32'(done));
      end
      enable <= 1'b0;
      sample_cycle();                 // Edge that returns to idle
      sample_cycle();
      check_value({case_label, " done release"}, 32'd0, 32'(done));
      check_value({case_label, " writes after done"},
                  32'(centre_count), 32'(write_count));
      for (int k = 0; k < centre_count; k++) begin
        check_value({case_label, $sformatf(" result %0d", k)},
                    expected[k], mem[18'(pixel_count + 1 + k)]);
        checked_count++;
      end
    end
    repeat (2) sample_cycle();        // Idle gap between cases
  endtask

  initial begin
    reset         = 1'b1;
    enable        = 1'b0;
    error_count   = 0;
    checked_count = 0;
    write_count   = 0;
    wren_prev     = 1'b0;
    case_label    = "reset";
    load_cases();
    fill_memory(mode_ramp);           // No X on data_read during reset
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    sample_cycle();
    sample_cycle();
    check_value("reset wren", 32'd0, 32'(wren));
    check_value("reset done", 32'd0, 32'(done));
    check_value("reset address", 32'd0, 32'(address));
    for (int i = 0; i < case_count; i++) begin
      run_case(i);
    end
    $display("errors %0d, results checked %0d, cycles %0d",
             error_count, checked_count, cycle_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- hdl/median_filter.sv
`timescale 1ns/10ps

// 3x3 median filter over an RGB image in word-addressed memory
// Sequencer walks the centres, capture collects the window,
// one sorting network per channel produces the median
module median_filter #(
  parameter int image_width  = 320,
  parameter int image_height = 240
) (
  input  logic                                        clk,
  input  logic                                        reset,
  input  logic                                        enable,      // Level, holds the pass running
  input  logic [median_filter_pkg::word_width-1:0]    data_read,   // One cycle after address
  output logic [median_filter_pkg::address_width-1:0] address,
  output logic [median_filter_pkg::word_width-1:0]    data_write,
  output logic                                        wren,
  output logic                                        done
);

  logic [median_filter_pkg::step_width-1:0]    step;

  // Per-channel windows, slot 0 in the low byte
  logic [median_filter_pkg::window_width-1:0]  red_window;
  logic [median_filter_pkg::window_width-1:0]  green_window;
  logic [median_filter_pkg::window_width-1:0]  blue_window;

  logic [median_filter_pkg::channel_width-1:0] red_median;
  logic [median_filter_pkg::channel_width-1:0] green_median;
  logic [median_filter_pkg::channel_width-1:0] blue_median;

  window_sequencer #(
    .image_width  (image_width),
    .image_height (image_height)
  ) i_window_sequencer (
    .clk     (clk),
    .reset   (reset),
    .enable  (enable),
    .step    (step),
    .address (address),
    .wren    (wren),
    .done    (done)
  );

  window_capture i_window_capture (
    .clk          (clk),
    .reset        (reset),
    .step         (step),
    .data_read    (data_read),
    .red_window   (red_window),
    .green_window (green_window),
    .blue_window  (blue_window)
  );

  channel_median i_red_median (
    .window (red_window),
    .median (red_median)
  );

  channel_median i_green_median (
    .window (green_window),
    .median (green_median)
  );

  channel_median i_blue_median (
    .window (blue_window),
    .median (blue_median)
  );

  // Same layout as a pixel word, byte 2 left clear
  assign data_write = {blue_median,
                       {median_filter_pkg::channel_width{1'b0}},
                       green_median,
                       red_median};

endmodule

//--- hdl/window_sequencer.sv
`timescale 1ns/10ps

// Pass control for the median filter
// Each centre takes 11 cycles: nine reads, one wait, one write
module window_sequencer #(
  parameter int image_width  = 320,
  parameter int image_height = 240
) (
  input  logic                                        clk,
  input  logic                                        reset,
  input  logic                                        enable,
  output logic [median_filter_pkg::step_width-1:0]    step,
  output logic [median_filter_pkg::address_width-1:0] address,
  output logic                                        wren,
  output logic                                        done
);

  localparam int aw = median_filter_pkg::address_width;

  localparam logic [aw-1:0] one_pixel   = aw'(1);
  localparam logic [aw-1:0] one_row     = aw'(image_width);
  // Results go just past the image and its guard word
  localparam logic [aw-1:0] result_base = aw'(image_width * image_height + 1);
  // Rows 0 and image_height-1 are never centres
  localparam logic [aw-1:0] last_centre = aw'(image_width * (image_height - 2) - 1);

  logic [median_filter_pkg::state_width-1:0] state;
  logic [aw-1:0] centre;             // Centre number k within the pass
  logic [aw-1:0] centre_address;
  logic [aw-1:0] neighbour_address;
  logic [aw-1:0] result_address;
  logic          last_step;

  assign last_step = (step == median_filter_pkg::steps_per_pixel - 1'b1);

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= median_filter_pkg::state_idle;
      step   <= '0;
      centre <= '0;
    end else if (!enable) begin
      // Abort mid-pass or release after done
      state  <= median_filter_pkg::state_idle;
      step   <= '0;
      centre <= '0;
    end else begin
      case (state)
        median_filter_pkg::state_idle: begin
          state <= median_filter_pkg::state_holdoff;
        end
        median_filter_pkg::state_holdoff: begin
          state  <= median_filter_pkg::state_run;   // Step 0 of centre 0 next
          step   <= '0;
          centre <= '0;
        end
        median_filter_pkg::state_run: begin
          if (last_step) begin
            step <= '0;
            if (centre == last_centre) begin
              state <= median_filter_pkg::state_done;
            end else begin
              centre <= centre + one_pixel;
            end
          end else begin
            step <= step + 1'b1;
          end
        end
        default: begin
          // Done, hold until enable falls
          step <= '0;
        end
      endcase
    end
  end

  assign centre_address = one_row + centre;          // Row 1 onwards
  assign result_address = result_base + centre;

  // Read order: centre, left, right, top-right, top, top-left,
  // bottom-left, bottom, bottom-right
  // Left and right wrap across row ends, no edge handling
  always_comb begin
    case (step)
      4'd1:    neighbour_address = centre_address - one_pixel;
      4'd2:    neighbour_address = centre_address + one_pixel;
      4'd3:    neighbour_address = centre_address - one_row + one_pixel;
      4'd4:    neighbour_address = centre_address - one_row;
      4'd5:    neighbour_address = centre_address - one_row - one_pixel;
      4'd6:    neighbour_address = centre_address + one_row - one_pixel;
      4'd7:    neighbour_address = centre_address + one_row;
      4'd8:    neighbour_address = centre_address + one_row + one_pixel;
      default: neighbour_address = centre_address;    // Step 0 and the wait step
    endcase
  end

  always_comb begin
    address = '0;                                       // Bus parked at zero outside a pass
    if (state == median_filter_pkg::state_run) begin
      if (step == median_filter_pkg::write_step) begin
        address = result_address;
      end else if (step < median_filter_pkg::read_steps) begin
        address = neighbour_address;
      end else begin
        address = centre_address;                       // Wait step, nothing returned used
      end
    end
  end

  // One-cycle strobe per centre
  assign wren = (state == median_filter_pkg::state_run) &&
                (step == median_filter_pkg::write_step);

  assign done = (state == median_filter_pkg::state_done);

endmodule

//--- hdl/window_capture.sv
`timescale 1ns/10ps

// Collects the nine window pixels as they come back from memory
// Read issued in step s returns in step s+1 and lands in slot s
module window_capture (
  input  logic                                       clk,
  input  logic                                       reset,
  input  logic [median_filter_pkg::step_width-1:0]   step,
  input  logic [median_filter_pkg::word_width-1:0]   data_read,
  output logic [median_filter_pkg::window_width-1:0] red_window,
  output logic [median_filter_pkg::window_width-1:0] green_window,
  output logic [median_filter_pkg::window_width-1:0] blue_window
);

  localparam int cw = median_filter_pkg::channel_width;

  logic [cw-1:0] red_pixel;
  logic [cw-1:0] green_pixel;
  logic [cw-1:0] blue_pixel;
  logic [median_filter_pkg::step_width-1:0] slot;   // Slot for the returning word
  logic load;

  // Colour fields of the returning word
  assign red_pixel   = data_read[median_filter_pkg::red_lsb   +: cw];
  assign green_pixel = data_read[median_filter_pkg::green_lsb +: cw];
  assign blue_pixel  = data_read[median_filter_pkg::blue_lsb  +: cw];

  assign slot = step - 1'b1;

  // Steps 1..9 carry window data, step 0 sees the previous write cycle
  assign load = (step != '0) && (step <= median_filter_pkg::read_steps);

  always_ff @(posedge clk) begin
    if (reset) begin
      red_window   <= '0;
      green_window <= '0;
      blue_window  <= '0;
    end else if (load) begin
      red_window[slot*cw +: cw]   <= red_pixel;
      green_window[slot*cw +: cw] <= green_pixel;
      blue_window[slot*cw +: cw]  <= blue_pixel;
    end
  end

endmodule

//--- hdl/channel_median.sv
`timescale 1ns/10ps

// Median of nine bytes by a 19-exchange network
// Only slot 4 is fully ordered at the end, enough for the median
module channel_median (
  input  logic [median_filter_pkg::window_width-1:0]  window,
  output logic [median_filter_pkg::channel_width-1:0] median
);

  localparam int cw = median_filter_pkg::channel_width;

  logic [cw-1:0] v [median_filter_pkg::window_size];  // Working copy of the window
  logic [cw-1:0] middle;

  // Smaller value to the first position
  function automatic logic [2*cw-1:0] order(input logic [cw-1:0] a,
                                            input logic [cw-1:0] b);
    return (a > b) ? {b, a} : {a, b};
  endfunction

  always_comb begin
    // Unpack, slot 0 is the centre pixel
    for (int i = 0; i < median_filter_pkg::window_size; i++) begin
      v[i] = window[i*cw +: cw];
    end

    // Sort the three triples
    {v[1], v[2]} = order(v[1], v[2]);
    {v[4], v[5]} = order(v[4], v[5]);
    {v[7], v[8]} = order(v[7], v[8]);
    {v[0], v[1]} = order(v[0], v[1]);
    {v[3], v[4]} = order(v[3], v[4]);
    {v[6], v[7]} = order(v[6], v[7]);
    {v[1], v[2]} = order(v[1], v[2]);
    {v[4], v[5]} = order(v[4], v[5]);
    {v[7], v[8]} = order(v[7], v[8]);

    // Max of the mins, min of the maxes
    {v[0], v[3]} = order(v[0], v[3]);
    {v[5], v[8]} = order(v[5], v[8]);
    {v[4], v[7]} = order(v[4], v[7]);
    {v[3], v[6]} = order(v[3], v[6]);   // v[6] now max of mins
    {v[1], v[4]} = order(v[1], v[4]);
    {v[2], v[5]} = order(v[2], v[5]);   // v[2] now min of maxes
    {v[4], v[7]} = order(v[4], v[7]);   // v[4] median of middles

    // Median of the three candidates ends in slot 4
    {v[4], v[2]} = order(v[4], v[2]);
    {v[6], v[4]} = order(v[6], v[4]);
    {v[4], v[2]} = order(v[4], v[2]);

    middle = v[4];
  end

  // Keep 255 free for the edge detector
  assign median = (middle == median_filter_pkg::reserved_value) ?
                  median_filter_pkg::clamp_value : middle;

endmodule

//--- hdl/median_filter_pkg.sv
package median_filter_pkg;

  // Memory word and pixel layout
  localparam int channel_width = 8;
  localparam int word_width    = 32;
  localparam int address_width = 18;

  // Low bit of each colour field, bits 23:16 unused
  localparam int red_lsb   = 0;
  localparam int green_lsb = 8;
  localparam int blue_lsb  = 24;

  // 3x3 window, one byte per slot per channel
  localparam int window_size  = 9;
  localparam int window_width = window_size * channel_width;

  // Per-pixel step schedule
  localparam int step_width = 4;
  localparam logic [step_width-1:0] read_steps      = 4'd9;   // Steps 0..8 issue reads
  localparam logic [step_width-1:0] write_step      = 4'd10;  // Result write
  localparam logic [step_width-1:0] steps_per_pixel = 4'd11;

  // 255 marks an edge downstream, so a median never takes it
  localparam logic [channel_width-1:0] reserved_value = 8'd255;
  localparam logic [channel_width-1:0] clamp_value    = 8'd254;

  // Sequencer states
  localparam int state_width = 2;
  localparam logic [state_width-1:0] state_idle    = 2'd0;
  localparam logic [state_width-1:0] state_holdoff = 2'd1;  // One cycle before the first read
  localparam logic [state_width-1:0] state_run     = 2'd2;
  localparam logic [state_width-1:0] state_done    = 2'd3;  // Waits for enable to drop

endpackage
